/* compile.f */
verilog/md_hal_pkg.sv
verilog/download_bus_if.sv
verilog/hal_config_regs.sv
verilog/cart_header_scan.sv
verilog/region_select.sv
verilog/cheat_code_loader.sv
verilog/md_hal_top.sv
test/md_hal_checker.sv
test/md_hal_properties.sv
test/md_hal_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the md_hal testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module md_hal_tb \
	-o sim_md_hal --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_md_hal > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* test/md_hal_tb.sv */
`timescale 1ns/1ps

module md_hal_tb;
	import md_hal_pkg::*;

	localparam int NUM_ROWS  = 21;
	localparam int MAX_CYC   = NUM_ROWS * 400;
	// Row kinds
	localparam int K_READ  = 0;
	localparam int K_WRITE = 1;
	localparam int K_BAD   = 2;
	localparam int K_CART  = 3;
	localparam int K_CODE  = 4;

	logic clk_sys = 1'b0;
	logic sys_reset;
	logic psel, penable, pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata, prdata;
	logic pready, pslverr;
	logic dl_active, dl_wr;
	dl_addr_t dl_addr;
	dl_data_t dl_data;
	dl_index_t dl_index;
	region_t region;
	logic pal, jap, cheat_valid;
	cheat_code_t cheat_code;
	logic chk_stb;
	logic [1:0] chk_kind;
	logic [127:0] chk_name, chk_exp;
	int pass_cnt, fail_cnt, tb_fail, cycles, n_rows, i, seed;

	// Stimulus table
	logic [127:0] t_name [NUM_ROWS];
	int           t_kind [NUM_ROWS];
	apb_addr_t    t_addr [NUM_ROWS];
	apb_data_t    t_wdata [NUM_ROWS];
	logic [15:0]  t_hdr1 [NUM_ROWS];
	logic [15:0]  t_hdr2 [NUM_ROWS];
	dl_index_t    t_index [NUM_ROWS];
	logic [127:0] t_exp [NUM_ROWS];

	always #50 clk_sys = ~clk_sys;

	md_hal_top u_md_hal_top (
		.clk_sys(clk_sys), .sys_reset(sys_reset), .psel_i(psel), .penable_i(penable),
		.pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
		.pready_o(pready), .pslverr_o(pslverr), .dl_active_i(dl_active), .dl_wr_i(dl_wr),
		.dl_addr_i(dl_addr), .dl_data_i(dl_data), .dl_index_i(dl_index), .region_o(region),
		.pal_o(pal), .jap_o(jap), .cheat_valid_o(cheat_valid), .cheat_code_o(cheat_code)
	);

	md_hal_checker u_md_hal_checker (
		.clk_sys(clk_sys), .chk_stb_i(chk_stb), .chk_kind_i(chk_kind),
		.chk_name_i(chk_name), .chk_exp_i(chk_exp), .prdata_i(prdata), .pslverr_i(pslverr),
		.region_i(region), .pal_i(pal), .jap_i(jap), .cheat_code_i(cheat_code),
		.pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt)
	);

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYC) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	task automatic add_row(input logic [127:0] name, input int kind, input apb_addr_t a,
		input apb_data_t wd, input logic [15:0] h1, input logic [15:0] h2,
		input dl_index_t idx, input logic [127:0] exp);
		t_name[n_rows]  = name;
		t_kind[n_rows]  = kind;
		t_addr[n_rows]  = a;
		t_wdata[n_rows] = wd;
		t_hdr1[n_rows]  = h1;
		t_hdr2[n_rows]  = h2;
		t_index[n_rows] = idx;
		t_exp[n_rows]   = exp;
		n_rows = n_rows + 1;
	endtask

	// One APB transfer, optional check in its access phase
	task automatic apb_xfer(input logic wr, input apb_addr_t a, input apb_data_t d,
		input logic chk, input logic [1:0] kind, input logic [127:0] exp);
		@(negedge clk_sys);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = a;
		pwdata  = d;
		@(negedge clk_sys);
		penable  = 1'b1;
		chk_stb  = chk;
		chk_kind = kind;
		chk_exp  = exp;
		@(negedge clk_sys);
		psel    = 1'b0;
		penable = 1'b0;
		chk_stb = 1'b0;
	endtask

	task automatic cart_download(input int r);
		int a;
		apb_xfer(1'b1, REG_CTRL, t_wdata[r], 1'b0, 2'd0, '0);
		dl_index  = t_index[r];
		dl_active = 1'b1;
		for (a = 0; a <= 'h200; a = a + 2) begin
			@(negedge clk_sys);
			dl_wr   = 1'b1;
			dl_addr = dl_addr_t'(a);
			if (a == 'h1F0)
				dl_data = t_hdr1[r];
			else if (a == 'h1F2)
				dl_data = t_hdr2[r];
			else
				dl_data = dl_data_t'($random(seed));
		end
		@(negedge clk_sys);
		dl_wr     = 1'b0;
		dl_active = 1'b0;
		// Region settles within 3 cycles of the end write
		repeat (3) @(negedge clk_sys);
		chk_kind = 2'd2;
		chk_exp  = t_exp[r];
		chk_stb  = 1'b1;
		@(negedge clk_sys);
		chk_stb = 1'b0;
	endtask

	task automatic code_download(input int r);
		int k;
		int n;
		dl_index  = CODE_INDEX;
		dl_active = 1'b1;
		for (k = 0; k <= 14; k = k + 2) begin
			@(negedge clk_sys);
			dl_wr   = 1'b1;
			dl_addr = dl_addr_t'(t_hdr1[r] + k);
			// Field 3 is flags at the top, low half first
			dl_data = t_exp[r][(3 - k / 4) * 32 + ((k / 2) % 2) * 16 +: 16];
		end
		@(negedge clk_sys);
		dl_wr     = 1'b0;
		dl_active = 1'b0;
		n = 0;
		while (!cheat_valid && n < 8) begin
			@(negedge clk_sys);
			n = n + 1;
		end
		if (!cheat_valid) begin
			$display("No cheat valid pulse seen in test %s", t_name[r]);
			tb_fail = tb_fail + 1;
		end
		chk_kind = 2'd3;
		chk_exp  = t_exp[r];
		chk_stb  = 1'b1;
		@(negedge clk_sys);
		chk_stb = 1'b0;
	endtask

	initial begin
		seed = 32'hab36;
		cycles = 0;
		tb_fail = 0;
		n_rows = 0;
		sys_reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		dl_index = '0;
		chk_stb = 1'b0;
		chk_kind = 2'd0;
		chk_name = '0;
		chk_exp = '0;

		add_row("rst_ctrl", K_READ, REG_CTRL, 0, 0, 0, 0, 128'h01);
		add_row("ctrl_wr", K_WRITE, REG_CTRL, 32'h36, 0, 0, 0, 128'h36);
		add_row("unmapped", K_BAD, 4'h8, 32'h3F, 0, 0, 0, 128'h1);
		add_row("p0_je", K_CART, 0, 32'h00, 16'h454A, 16'h2020, 8'h01, 128'd2);
		add_row("p1_uj", K_CART, 0, 32'h10, 16'h2055, 16'h204A, 8'h01, 128'd1);
		add_row("p2_ej", K_CART, 0, 32'h22, 16'h4A45, 16'h2020, 8'h01, 128'd0);
		add_row("p3_ue", K_CART, 0, 32'h30, 16'h4555, 16'h2020, 8'h01, 128'd1);
		add_row("p1_none", K_CART, 0, 32'h10, 16'h2020, 16'h2020, 8'h01, 128'd2);
		add_row("p3_none", K_CART, 0, 32'h31, 16'h2020, 16'h2020, 8'h01, 128'd0);
		add_row("digit_4", K_CART, 0, 32'h00, 16'h2034, 16'h2020, 8'h01, 128'd1);
		add_row("hex_A", K_CART, 0, 32'h00, 16'h2041, 16'h2020, 8'h01, 128'd2);
		add_row("digit_1", K_CART, 0, 32'h01, 16'h2031, 16'h2020, 8'h01, 128'd0);
		add_row("file_ext", K_CART, 0, 32'h04, 16'h2055, 16'h2020, 8'h81, 128'd2);
		add_row("disabled", K_CART, 0, 32'h08, 16'h2045, 16'h2020, 8'h01, 128'd0);
		add_row("sms_cart", K_CART, 0, 32'h00, 16'h2045, 16'h2020, 8'h02, 128'd0);
		add_row("code_0", K_CODE, 0, 0, 16'd0, 0, 0, 128'h8001_0002_0012_3456_A5A5_0000_1F2E_3D4C);
		add_row("code_1", K_CODE, 0, 0, 16'd16, 0, 0, 128'h0000_0003_00FF_0010_0000_1234_CAFE_BABE);
		add_row("code_2", K_CODE, 0, 0, 16'd32, 0, 0, 128'h4000_0000_0001_FFFE_7777_8888_9999_AAAA);
		add_row("status_3", K_READ, REG_STATUS, 0, 0, 0, 0, 128'd3);
		add_row("code_new", K_CODE, 0, 0, 16'd0, 0, 0, 128'h1111_2222_0033_4444_5555_6666_7777_0088);
		add_row("status_1", K_READ, REG_STATUS, 0, 0, 0, 0, 128'd1);

		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		sys_reset = 1'b0;

		for (i = 0; i < n_rows; i = i + 1) begin
			chk_name = t_name[i];
			case (t_kind[i])
				K_READ: apb_xfer(1'b0, t_addr[i], '0, 1'b1, 2'd0, t_exp[i]);
				K_WRITE: begin
					apb_xfer(1'b1, t_addr[i], t_wdata[i], 1'b0, 2'd0, '0);
					apb_xfer(1'b0, t_addr[i], '0, 1'b1, 2'd0, t_exp[i]);
				end
				K_BAD: apb_xfer(1'b1, t_addr[i], t_wdata[i], 1'b1, 2'd1, t_exp[i]);
				K_CART: cart_download(i);
				default: code_download(i);
			endcase
		end

		repeat (2) @(negedge clk_sys);
		$display("Tests: %0d passed, %0d failed, %0d other errors", pass_cnt, fail_cnt, tb_fail);
		if (fail_cnt == 0 && tb_fail == 0 && pass_cnt == n_rows) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* test/md_hal_properties.sv */
`timescale 1ns/1ps

module md_hal_properties (
	input logic clk_sys,
	input logic sys_reset,
	input logic cheat_valid_o,
	input logic pready_o,
	input logic pal_o,
	input logic jap_o
);

	// Valid is a single-cycle pulse
	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (sys_reset)
		cheat_valid_o |=> !cheat_valid_o)
		else $error("cheat_valid_o stayed high for two cycles");

	a_pready: assert property (@(posedge clk_sys) disable iff (sys_reset) pready_o)
		else $error("pready_o went low");

	a_pal_jap: assert property (@(posedge clk_sys) disable iff (sys_reset) !(pal_o && jap_o))
		else $error("pal_o and jap_o both high");

endmodule

bind md_hal_top md_hal_properties u_md_hal_properties (
	.clk_sys(clk_sys), .sys_reset(sys_reset), .cheat_valid_o(cheat_valid_o),
	.pready_o(pready_o), .pal_o(pal_o), .jap_o(jap_o)
);

/* test/md_hal_checker.sv */
`timescale 1ns/1ps

module md_hal_checker (
	input  logic                    clk_sys,
	input  logic                    chk_stb_i,
	input  logic [1:0]              chk_kind_i,
	input  logic [127:0]            chk_name_i,
	input  logic [127:0]            chk_exp_i,
	input  md_hal_pkg::apb_data_t   prdata_i,
	input  logic                    pslverr_i,
	input  md_hal_pkg::region_t     region_i,
	input  logic                    pal_i,
	input  logic                    jap_i,
	input  md_hal_pkg::cheat_code_t cheat_code_i,
	output int                      pass_cnt_o,
	output int                      fail_cnt_o
);
	import md_hal_pkg::*;

	// Check kinds
	localparam logic [1:0] CK_READ   = 2'd0;
	localparam logic [1:0] CK_SLVERR = 2'd1;
	localparam logic [1:0] CK_REGION = 2'd2;
	localparam logic [1:0] CK_CODE   = 2'd3;

	initial begin
		pass_cnt_o = 0;
		fail_cnt_o = 0;
	end

	always @(posedge clk_sys) begin
		logic ok;
		ok = 1'b1;
		if (chk_stb_i) begin
			case (chk_kind_i)
				CK_READ: if (prdata_i !== chk_exp_i[31:0]) begin
					$display("[ERROR] %s expected %h actual %h", chk_name_i,
						chk_exp_i[31:0], prdata_i);
					ok = 1'b0;
				end
				CK_SLVERR: if (pslverr_i !== 1'b1) begin
					$display("[ERROR] %s expected 1 actual %b", chk_name_i, pslverr_i);
					ok = 1'b0;
				end
				CK_REGION: begin
					if (region_i !== chk_exp_i[1:0]) begin
						$display("[ERROR] %s expected %0d actual %0d", chk_name_i,
							chk_exp_i[1:0], region_i);
						ok = 1'b0;
					end
					// PAL for Europe, Japan flag for JP
					if (pal_i !== (chk_exp_i[1:0] == 2'd2) ||
						jap_i !== (chk_exp_i[1:0] == 2'd0)) begin
						$display("[ERROR] %s expected pal/jap %b%b actual %b%b", chk_name_i,
							chk_exp_i[1:0] == 2'd2, chk_exp_i[1:0] == 2'd0, pal_i, jap_i);
						ok = 1'b0;
					end
				end
				CK_CODE: if (cheat_code_i !== chk_exp_i) begin
					$display("[ERROR] %s expected %h actual %h", chk_name_i,
						chk_exp_i, cheat_code_i);
					ok = 1'b0;
				end
			endcase
			if (ok) begin
				$display("PASS %s", chk_name_i);
				pass_cnt_o = pass_cnt_o + 1;
			end else begin
				fail_cnt_o = fail_cnt_o + 1;
			end
		end
	end

endmodule

/* verilog/md_hal_top.sv */
`timescale 1ns/1ps

module md_hal_top (
	input  logic                    clk_sys,
	input  logic                    sys_reset,
	input  logic                    psel_i,
	input  logic                    penable_i,
	input  logic                    pwrite_i,
	input  md_hal_pkg::apb_addr_t   paddr_i,
	input  md_hal_pkg::apb_data_t   pwdata_i,
	output md_hal_pkg::apb_data_t   prdata_o,
	output logic                    pready_o,
	output logic                    pslverr_o,
	input  logic                    dl_active_i,
	input  logic                    dl_wr_i,
	input  md_hal_pkg::dl_addr_t    dl_addr_i,
	input  md_hal_pkg::dl_data_t    dl_data_i,
	input  md_hal_pkg::dl_index_t   dl_index_i,
	output md_hal_pkg::region_t     region_o,
	output logic                    pal_o,
	output logic                    jap_o,
	output logic                    cheat_valid_o,
	output md_hal_pkg::cheat_code_t cheat_code_o
);
	import md_hal_pkg::*;

	logic       hdr_j;
	logic       hdr_u;
	logic       hdr_e;
	logic       hdr_ready;
	logic       cart_sms;
	logic       region_upd_valid;
	region_t    region_upd;
	logic [1:0] auto_mode;
	logic [1:0] priority_sel;
	logic [7:0] cheat_count;

	////////////////////////////////////////////////////////////
	// Download stream
	////////////////////////////////////////////////////////////

	download_bus_if dl_bus ();

	assign dl_bus.dl_active = dl_active_i;
	assign dl_bus.dl_wr     = dl_wr_i;
	assign dl_bus.dl_addr   = dl_addr_i;
	assign dl_bus.dl_data   = dl_data_i;
	assign dl_bus.dl_index  = dl_index_i;

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	hal_config_regs u_hal_config_regs (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
		.pready_o(pready_o), .pslverr_o(pslverr_o),
		.region_upd_valid_i(region_upd_valid), .region_upd_i(region_upd),
		.cheat_count_i(cheat_count), .auto_mode_o(auto_mode), .priority_o(priority_sel),
		.region_o(region_o), .pal_o(pal_o), .jap_o(jap_o)
	);

	cart_header_scan u_cart_header_scan (
		.clk_sys(clk_sys), .sys_reset(sys_reset), .dl(dl_bus.sink),
		.hdr_j_o(hdr_j), .hdr_u_o(hdr_u), .hdr_e_o(hdr_e),
		.hdr_ready_o(hdr_ready), .cart_sms_o(cart_sms)
	);

	region_select u_region_select (
		.clk_sys(clk_sys), .sys_reset(sys_reset), .dl(dl_bus.sink),
		.hdr_j_i(hdr_j), .hdr_u_i(hdr_u), .hdr_e_i(hdr_e),
		.hdr_ready_i(hdr_ready), .cart_sms_i(cart_sms),
		.auto_mode_i(auto_mode), .priority_i(priority_sel),
		.region_upd_valid_o(region_upd_valid), .region_upd_o(region_upd)
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys(clk_sys), .sys_reset(sys_reset), .dl(dl_bus.sink),
		.cheat_valid_o(cheat_valid_o), .cheat_code_o(cheat_code_o),
		.cheat_count_o(cheat_count)
	);

endmodule

/* verilog/cheat_code_loader.sv */
`timescale 1ns/1ps

module cheat_code_loader (
	input  logic                    clk_sys,
	input  logic                    sys_reset,
	download_bus_if.sink            dl,
	output logic                    cheat_valid_o,
	output md_hal_pkg::cheat_code_t cheat_code_o,
	output logic [7:0]              cheat_count_o
);
	import md_hal_pkg::*;

	logic        code_dl;
	logic        code_wr;
	logic        code_done;
	logic        valid_q;
	logic [7:0]  count_q;
	cheat_code_t code_q;

	assign code_dl   = dl.dl_active & (dl.dl_index == CODE_INDEX);
	assign code_wr   = code_dl & dl.dl_wr;
	// Last word of a 16-byte record
	assign code_done = code_wr & (dl.dl_addr[3:0] == 4'd14);

	// Word placement within the record
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.dl_addr[3:0])
				4'd0:    code_q[111:96]  <= dl.dl_data;
				4'd2:    code_q[127:112] <= dl.dl_data;
				4'd4:    code_q[79:64]   <= dl.dl_data;
				4'd6:    code_q[95:80]   <= dl.dl_data;
				4'd8:    code_q[47:32]   <= dl.dl_data;
				4'd10:   code_q[63:48]   <= dl.dl_data;
				4'd12:   code_q[15:0]    <= dl.dl_data;
				4'd14:   code_q[31:16]   <= dl.dl_data;
				default: code_q          <= code_q;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			valid_q <= 1'b0;
			count_q <= 8'd0;
		end else begin
			valid_q <= code_done;
			// New file restarts the count
			if (code_wr && dl.dl_addr == '0) begin
				count_q <= 8'd0;
			end
			if (code_done && count_q != 8'hFF) begin
				count_q <= count_q + 8'd1;
			end
		end
	end

	assign cheat_valid_o = valid_q;
	assign cheat_code_o  = code_q;
	assign cheat_count_o = count_q;

endmodule

/* verilog/region_select.sv */
`timescale 1ns/1ps

module region_select (
	input  logic                clk_sys,
	input  logic                sys_reset,
	download_bus_if.sink        dl,
	input  logic                hdr_j_i,
	input  logic                hdr_u_i,
	input  logic                hdr_e_i,
	input  logic                hdr_ready_i,
	input  logic                cart_sms_i,
	input  logic [1:0]          auto_mode_i,
	input  logic [1:0]          priority_i,
	output logic                region_upd_valid_o,
	output md_hal_pkg::region_t region_upd_o
);
	import md_hal_pkg::*;

	logic    ready_q;
	logic    hdr_rise;
	logic    auto_en;
	logic    upd_valid_q;
	region_t hdr_region;
	region_t next_region;
	region_t upd_region_q;

	assign hdr_rise = hdr_ready_i & ~ready_q;
	// SMS carts and disabled modes keep the current region
	assign auto_en  = ~cart_sms_i &
		((auto_mode_i == AUTO_HEADER) || (auto_mode_i == AUTO_FILE_EXT));

	// First flag present wins, per priority order
	always_comb begin
		case (priority_i)
			2'd0: begin
				if (hdr_u_i)      hdr_region = REGION_US;
				else if (hdr_e_i) hdr_region = REGION_EU;
				else if (hdr_j_i) hdr_region = REGION_JP;
				else              hdr_region = REGION_US;
			end
			2'd1: begin
				if (hdr_e_i)      hdr_region = REGION_EU;
				else if (hdr_u_i) hdr_region = REGION_US;
				else if (hdr_j_i) hdr_region = REGION_JP;
				else              hdr_region = REGION_EU;
			end
			2'd2: begin
				if (hdr_u_i)      hdr_region = REGION_US;
				else if (hdr_j_i) hdr_region = REGION_JP;
				else if (hdr_e_i) hdr_region = REGION_EU;
				else              hdr_region = REGION_US;
			end
			default: begin
				if (hdr_j_i)      hdr_region = REGION_JP;
				else if (hdr_u_i) hdr_region = REGION_US;
				else if (hdr_e_i) hdr_region = REGION_EU;
				else              hdr_region = REGION_JP;
			end
		endcase
	end

	// File extension mode takes the index top bits
	assign next_region = (auto_mode_i == AUTO_FILE_EXT) ? dl.dl_index[7:6] : hdr_region;

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			ready_q     <= 1'b0;
			upd_valid_q <= 1'b0;
		end else begin
			ready_q     <= hdr_ready_i;
			upd_valid_q <= hdr_rise & auto_en;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (hdr_rise) begin
			upd_region_q <= next_region;
		end
	end

	assign region_upd_valid_o = upd_valid_q;
	assign region_upd_o       = upd_region_q;

endmodule

/* verilog/cart_header_scan.sv */
`timescale 1ns/1ps

module cart_header_scan (
	input  logic           clk_sys,
	input  logic           sys_reset,
	download_bus_if.sink   dl,
	output logic           hdr_j_o,
	output logic           hdr_u_o,
	output logic           hdr_e_o,
	output logic           hdr_ready_o,
	output logic           cart_sms_o
);
	import md_hal_pkg::*;

	logic       cart_dl;
	logic       cart_dl_q;
	logic       cart_start;
	logic       cart_end;
	logic       cart_wr;
	logic [7:0] lo_byte;
	logic [7:0] hi_byte;
	logic [3:0] hex_nib;
	logic [2:0] lo_mask;
	logic [2:0] hi_mask;
	// Ordered {e, u, j}
	logic [2:0] flags_q;
	logic [2:0] flags_nxt;
	logic       hdr_ready_q;
	logic       cart_sms_q;

	// Region letter to flag bit
	function automatic logic [2:0] letter_mask(input logic [7:0] ch);
		logic [2:0] mask;
		case (ch)
			"J":     mask = 3'b001;
			"U":     mask = 3'b010;
			"E":     mask = 3'b100;
			default: mask = 3'b000;
		endcase
		return mask;
	endfunction

	assign cart_dl    = dl.dl_active &
		((dl.dl_index[4:0] == CART_INDEX_MD) || (dl.dl_index[4:0] == CART_INDEX_SMS));
	assign cart_start = cart_dl & ~cart_dl_q;
	assign cart_end   = ~cart_dl & cart_dl_q;
	assign cart_wr    = cart_dl & dl.dl_wr;

	assign lo_byte = dl.dl_data[7:0];
	assign hi_byte = dl.dl_data[15:8];
	assign hex_nib = dl.dl_data[3:0] - 4'd7;
	assign lo_mask = letter_mask(lo_byte);
	assign hi_mask = letter_mask(hi_byte);

	always_comb begin
		flags_nxt = flags_q;
		if (cart_start) begin
			flags_nxt = 3'b000;
		end
		if (cart_wr && dl.dl_addr == HDR_REGION_ADDR) begin
			if (|lo_mask) begin
				flags_nxt = flags_nxt | lo_mask;
			end else if (lo_byte >= "0" && lo_byte <= "9") begin
				flags_nxt = {lo_byte[3], lo_byte[2], lo_byte[0]};
			end else if (lo_byte >= "A" && lo_byte <= "F") begin
				flags_nxt = {hex_nib[3], hex_nib[2], hex_nib[0]};
			end
			// High byte only adds letters
			flags_nxt = flags_nxt | hi_mask;
		end
		if (cart_wr && dl.dl_addr == HDR_REGION_ADDR2) begin
			flags_nxt = flags_nxt | lo_mask;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			cart_dl_q   <= 1'b0;
			flags_q     <= 3'b000;
			hdr_ready_q <= 1'b0;
			cart_sms_q  <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			flags_q   <= flags_nxt;
			if (cart_start) begin
				cart_sms_q <= (dl.dl_index[4:0] == CART_INDEX_SMS);
			end
			if (cart_end) begin
				hdr_ready_q <= 1'b0;
			end
			// Header fully seen
			if (cart_wr && dl.dl_addr == HDR_END_ADDR) begin
				hdr_ready_q <= 1'b1;
			end
		end
	end

	assign hdr_j_o     = flags_q[0];
	assign hdr_u_o     = flags_q[1];
	assign hdr_e_o     = flags_q[2];
	assign hdr_ready_o = hdr_ready_q;
	assign cart_sms_o  = cart_sms_q;

endmodule

/* verilog/hal_config_regs.sv */
`timescale 1ns/1ps

module hal_config_regs (
	input  logic                  clk_sys,
	input  logic                  sys_reset,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  md_hal_pkg::apb_addr_t paddr_i,
	input  md_hal_pkg::apb_data_t pwdata_i,
	output md_hal_pkg::apb_data_t prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	input  logic                  region_upd_valid_i,
	input  md_hal_pkg::region_t   region_upd_i,
	input  logic [7:0]            cheat_count_i,
	output logic [1:0]            auto_mode_o,
	output logic [1:0]            priority_o,
	output md_hal_pkg::region_t   region_o,
	output logic                  pal_o,
	output logic                  jap_o
);
	import md_hal_pkg::*;

	logic       access;
	logic       addr_ok;
	logic       ctrl_wr;
	region_t    region_q;
	logic [1:0] mode_q;
	logic [1:0] prio_q;

	// Access phase decode
	assign access   = psel_i & penable_i;
	assign addr_ok  = (paddr_i == REG_CTRL) || (paddr_i == REG_STATUS);
	assign ctrl_wr  = access & pwrite_i & (paddr_i == REG_CTRL);

	// Zero wait states
	assign pready_o  = 1'b1;
	assign pslverr_o = access & ~addr_ok;

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			region_q <= REGION_US;
			mode_q   <= AUTO_HEADER;
			prio_q   <= 2'd0;
		end else begin
			if (ctrl_wr) begin
				region_q <= pwdata_i[1:0];
				mode_q   <= pwdata_i[3:2];
				prio_q   <= pwdata_i[5:4];
			end
			// Hardware update beats a CTRL write in the same cycle
			if (region_upd_valid_i) begin
				region_q <= region_upd_i;
			end
		end
	end

	// Read mux, STATUS holds the cheat count
	always_comb begin
		prdata_o = '0;
		case (paddr_i)
			REG_CTRL:   prdata_o[5:0] = {prio_q, mode_q, region_q};
			REG_STATUS: prdata_o[7:0] = cheat_count_i;
			default:    prdata_o      = '0;
		endcase
	end

	assign auto_mode_o = mode_q;
	assign priority_o  = prio_q;
	assign region_o    = region_q;
	assign pal_o       = (region_q == REGION_EU);
	assign jap_o       = (region_q == REGION_JP);

endmodule

/* verilog/download_bus_if.sv */
`timescale 1ns/1ps

interface download_bus_if;
	import md_hal_pkg::*;

	logic      dl_active;
	logic      dl_wr;
	dl_addr_t  dl_addr;
	dl_data_t  dl_data;
	dl_index_t dl_index;

	// Driven from the top-level ports
	modport source (output dl_active, output dl_wr, output dl_addr, output dl_data,
		output dl_index);

	// No back-pressure, consumers take every word
	modport sink (input dl_active, input dl_wr, input dl_addr, input dl_data,
		input dl_index);

endinterface

/* verilog/md_hal_pkg.sv */
package md_hal_pkg;

	////////////////////////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////////////////////////

	// Byte address within a download
	typedef logic [24:0]  dl_addr_t;
	typedef logic [15:0]  dl_data_t;
	typedef logic [7:0]   dl_index_t;
	typedef logic [1:0]   region_t;
	typedef logic [3:0]   apb_addr_t;
	typedef logic [31:0]  apb_data_t;
	// Flags, address, compare, replace from the top down
	typedef logic [127:0] cheat_code_t;

	////////////////////////////////////////////////////////////
	// Constants
	////////////////////////////////////////////////////////////

	localparam region_t REGION_JP = 2'd0;
	localparam region_t REGION_US = 2'd1;
	localparam region_t REGION_EU = 2'd2;

	// Matched against the low 5 bits of the index
	localparam logic [4:0] CART_INDEX_MD  = 5'd1;
	localparam logic [4:0] CART_INDEX_SMS = 5'd2;
	localparam dl_index_t  CODE_INDEX     = 8'hFF;

	// Cartridge header locations
	localparam dl_addr_t HDR_REGION_ADDR  = 25'h1F0;
	localparam dl_addr_t HDR_REGION_ADDR2 = 25'h1F2;
	localparam dl_addr_t HDR_END_ADDR     = 25'h200;

	localparam apb_addr_t REG_CTRL   = 4'h0;
	localparam apb_addr_t REG_STATUS = 4'h4;

	// Auto region modes, 2 and 3 disable it
	localparam logic [1:0] AUTO_HEADER   = 2'd0;
	localparam logic [1:0] AUTO_FILE_EXT = 2'd1;

endpackage
